// File: all.f
+incdir+.
cpu_pkg.sv
alu.sv
flag_ctrl_decode.sv
status_reg.sv
flags_unit.sv
tb_flags_unit.sv

// File: alu.sv
`include "cpu_defines.svh"

module alu (
    input  cpu_pkg::alu_op_e     op,        // function select
    input  logic [`DATA_W-1:0]   a,         // accumulator side
    input  logic [`DATA_W-1:0]   b,         // memory / operand side
    input  logic                 carry_in,  // registered c flag
    output logic [`DATA_W-1:0]   result,
    output logic                 carry_out,
    output logic                 overflow
);
    import cpu_pkg::*;

    logic [`DATA_W-1:0] b_op; // b, inverted for subtract
    logic [`DATA_W:0]   sum;  // extra bit is the carry

    // sbc is a + ~b + c, so c=1 means no borrow
    assign b_op = (op == SBC) ? ~b : b;
    assign sum  = {1'b0, a} + {1'b0, b_op} + {{`DATA_W{1'b0}}, carry_in};

    always_comb begin
        result    = '0;
        carry_out = 1'b0; // no carry unless op makes one
        overflow  = 1'b0;
        case (op)
            ADC, SBC: begin
                result    = sum[`DATA_W-1:0];
                carry_out = sum[`DATA_W];
                // signed overflow, operands same sign but sum differs
                overflow  = (a[`DATA_W-1] == b_op[`DATA_W-1]) &&
                            (sum[`DATA_W-1] != a[`DATA_W-1]);
            end
            AND: begin
                result = a & b;
            end
            ORA: begin
                result = a | b;
            end
            EOR: begin
                result = a ^ b;
            end
            ASL: begin
                result    = {a[`DATA_W-2:0], 1'b0};
                carry_out = a[`DATA_W-1]; // msb falls out
            end
            LSR: begin
                result    = {1'b0, a[`DATA_W-1:1]};
                carry_out = a[0];         // lsb falls out
            end
            ROL: begin
                result    = {a[`DATA_W-2:0], carry_in}; // old c into lsb
                carry_out = a[`DATA_W-1];
            end
            ROR: begin
                result    = {carry_in, a[`DATA_W-1:1]}; // old c into msb
                carry_out = a[0];
            end
            PASS_B: begin
                result = b; // used by plp to put b on the bus
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath width, one byte
`define DATA_W 8

// 6502 status byte layout
`define FLAG_C 0 // carry
`define FLAG_Z 1 // zero
`define FLAG_I 2 // irq disable
`define FLAG_D 3 // decimal, stored only
`define FLAG_B 4 // break, shows brk level
`define FLAG_U 5 // unused bit, also brk level
`define FLAG_V 6 // overflow
`define FLAG_N 7 // negative

`endif

// File: cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    // alu function select
    typedef enum logic [3:0] {
        ADC    = 4'd0,  // a + b + c
        SBC    = 4'd1,  // a + ~b + c
        AND    = 4'd2,
        ORA    = 4'd3,
        EOR    = 4'd4,
        ASL    = 4'd5,  // shift left, 0 in
        LSR    = 4'd6,  // shift right, 0 in
        ROL    = 4'd7,  // rotate left through c
        ROR    = 4'd8,  // rotate right through c
        PASS_B = 4'd9   // b straight to result
    } alu_op_e;

    // per-cycle micro-op kind
    typedef enum logic [3:0] {
        NOP = 4'd0,
        ALU = 4'd1,  // alu op, flags per class
        PLP = 4'd2,  // load flags from bus
        CLC = 4'd3,
        SEC = 4'd4,
        CLI = 4'd5,
        SEI = 4'd6,
        CLD = 4'd7,
        SED = 4'd8,
        CLV = 4'd9
    } uop_code_e;

    typedef struct packed {
        uop_code_e code;
        alu_op_e   alu_op; // only meaningful for ALU and PLP
    } uop_t;

    // flag source enables, decoder guarantees one source per flag
    typedef struct packed {
        logic db_c;
        logic db_z;
        logic db_i;
        logic db_d;
        logic db_v;
        logic db_n;
        logic zero_z;     // z from whole bus == 0
        logic man_c;
        logic man_i;
        logic man_d;
        logic carry_c;    // c from alu carry out
        logic overflow_v; // v from alu overflow
        logic clear_v;
        logic manual_set; // value for man_* enables
    } flag_ctrl_t;

    // status byte, seen as raw bits or as named flags
    typedef union packed {
        logic [`DATA_W-1:0] bits;
        struct packed {
            logic n;
            logic v;
            logic u;
            logic b;
            logic d;
            logic i;
            logic z;
            logic c;
        } flags;
    } psr_t;

endpackage

// File: flag_ctrl_decode.sv
module flag_ctrl_decode (
    input  cpu_pkg::uop_t      uop,  // current micro-op
    output cpu_pkg::flag_ctrl_t ctrl // per-flag enables to status_reg
);
    import cpu_pkg::*;

    // one source per flag at most, so status_reg needs no priority
    always_comb begin
        ctrl = '0; // nop and unknown codes touch nothing
        case (uop.code)
            ALU: begin
                case (uop.alu_op)
                    ADC, SBC: begin
                        ctrl.zero_z     = 1'b1;
                        ctrl.db_n       = 1'b1; // n is bit 7 of result
                        ctrl.carry_c    = 1'b1;
                        ctrl.overflow_v = 1'b1;
                    end
                    AND, ORA, EOR, PASS_B: begin
                        ctrl.zero_z = 1'b1;
                        ctrl.db_n   = 1'b1;
                    end
                    ASL, LSR, ROL, ROR: begin
                        ctrl.zero_z  = 1'b1;
                        ctrl.db_n    = 1'b1;
                        ctrl.carry_c = 1'b1; // shifted-out bit
                    end
                    default: begin
                        ctrl = '0;
                    end
                endcase
            end
            PLP: begin
                // whole byte from bus, alu passes b through
                ctrl.db_c = 1'b1;
                ctrl.db_z = 1'b1;
                ctrl.db_i = 1'b1;
                ctrl.db_d = 1'b1;
                ctrl.db_v = 1'b1;
                ctrl.db_n = 1'b1;
            end
            CLC, SEC: begin
                ctrl.man_c      = 1'b1;
                ctrl.manual_set = (uop.code == SEC);
            end
            CLI, SEI: begin
                ctrl.man_i      = 1'b1;
                ctrl.manual_set = (uop.code == SEI);
            end
            CLD, SED: begin
                ctrl.man_d      = 1'b1;
                ctrl.manual_set = (uop.code == SED);
            end
            CLV: begin
                ctrl.clear_v = 1'b1; // no sev on 6502
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: flags_unit.sv
`include "cpu_defines.svh"

module flags_unit (
    input  logic                clk,
    input  logic                nrst,
    input  cpu_pkg::uop_t       uop,    // one micro-op per clock
    input  logic [`DATA_W-1:0]  a,
    input  logic [`DATA_W-1:0]  b,
    input  logic                brk,    // break level
    output logic [`DATA_W-1:0]  result, // alu result, same cycle
    output cpu_pkg::psr_t       psr     // status, one edge later
);
    import cpu_pkg::*;

    logic       carry;    // alu carry out
    logic       overflow; // alu signed overflow
    flag_ctrl_t ctrl;     // decoded flag enables

    // carry_in is the stored c, so adc/rol chain across cycles
    alu alu_i (
        .op        (uop.alu_op),
        .a         (a),
        .b         (b),
        .carry_in  (psr.flags.c),
        .result    (result),
        .carry_out (carry),
        .overflow  (overflow)
    );

    flag_ctrl_decode decode_i (
        .uop  (uop),
        .ctrl (ctrl)
    );

    // result doubles as the data bus into the register
    status_reg psr_i (
        .clk      (clk),
        .nrst     (nrst),
        .db       (result),
        .ctrl     (ctrl),
        .carry    (carry),
        .overflow (overflow),
        .brk      (brk),
        .psr      (psr)
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the flags_unit testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_flags_unit -o sim_flags_unit
./obj_dir/sim_flags_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0

// File: status_reg.sv
`include "cpu_defines.svh"

module status_reg (
    input  logic                clk,
    input  logic                nrst,     // async clear of all flags
    input  logic [`DATA_W-1:0]  db,       // data bus, alu result
    input  cpu_pkg::flag_ctrl_t ctrl,     // enables from decoder
    input  logic                carry,    // alu carry out
    input  logic                overflow, // alu overflow
    input  logic                brk,      // break level for bits 5 and 4
    output cpu_pkg::psr_t       psr
);
    import cpu_pkg::*;

    psr_t bus;        // db seen as flags
    psr_t q, q_nxt;   // stored flags, b and u kept at 0

    assign bus.bits = db;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            q <= '0;
        end else begin
            q <= q_nxt;
        end
    end

    // each flag is an OR of enabled sources, or a hold
    always_comb begin
        q_nxt.flags.c = (ctrl.db_c & bus.flags.c) |
                        (ctrl.man_c & ctrl.manual_set) |
                        (ctrl.carry_c & carry) |
                        (~(ctrl.db_c | ctrl.man_c | ctrl.carry_c) & q.flags.c);
        q_nxt.flags.z = (ctrl.db_z & bus.flags.z) |
                        (ctrl.zero_z & ~|db) |       // zero test of whole bus
                        (~(ctrl.db_z | ctrl.zero_z) & q.flags.z);
        q_nxt.flags.i = (ctrl.db_i & bus.flags.i) |
                        (ctrl.man_i & ctrl.manual_set) |
                        (~(ctrl.db_i | ctrl.man_i) & q.flags.i);
        q_nxt.flags.d = (ctrl.db_d & bus.flags.d) |
                        (ctrl.man_d & ctrl.manual_set) |
                        (~(ctrl.db_d | ctrl.man_d) & q.flags.d);
        // clear_v only drops the hold term, so v goes to 0
        q_nxt.flags.v = (ctrl.db_v & bus.flags.v) |
                        (ctrl.overflow_v & overflow) |
                        (~(ctrl.db_v | ctrl.overflow_v | ctrl.clear_v) & q.flags.v);
        q_nxt.flags.n = (ctrl.db_n & bus.flags.n) |
                        (~ctrl.db_n & q.flags.n);
        q_nxt.flags.b = 1'b0; // not stored, comes from brk
        q_nxt.flags.u = 1'b0;
    end

    // output byte, break level shown live
    always_comb begin
        psr.bits[`FLAG_C] = q.flags.c;
        psr.bits[`FLAG_Z] = q.flags.z;
        psr.bits[`FLAG_I] = q.flags.i;
        psr.bits[`FLAG_D] = q.flags.d;
        psr.bits[`FLAG_B] = brk;
        psr.bits[`FLAG_U] = brk;
        psr.bits[`FLAG_V] = q.flags.v;
        psr.bits[`FLAG_N] = q.flags.n;
    end

endmodule

// File: tb_flags_unit.sv
`include "cpu_defines.svh"

module tb_flags_unit;
    import cpu_pkg::*;

    localparam int N_RAND     = 2000;
    localparam int MAX_CYCLES = N_RAND + 1000; // random run plus reset and directed steps
    // error counter slot per behavior
    localparam int T_RESET  = 0;
    localparam int T_RESULT = 1;
    localparam int T_ARITH  = 2;
    localparam int T_SETCLR = 3;
    localparam int T_PLP    = 4;
    localparam int T_BRK    = 5;

    logic        clk;
    logic        nrst;
    uop_t        uop;
    logic [7:0]  a;
    logic [7:0]  b;
    logic        brk;
    logic [7:0]  result;
    psr_t        psr;

    psr_t        model_q;     // expected stored flags only
    logic [31:0] rng;
    int          errs [6];
    int          cycles;
    string       last_name;   // behavior of the micro-op now in psr
    int          last_cls;

    flags_unit dut_i (
        .clk    (clk),
        .nrst   (nrst),
        .uop    (uop),
        .a      (a),
        .b      (b),
        .brk    (brk),
        .result (result),
        .psr    (psr)
    );

    always #4 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reference alu giving {overflow, carry, result}
    function automatic logic [9:0] alu_model(input alu_op_e op, input logic [7:0] x,
                                             input logic [7:0] y, input logic cin);
        int         u;  // unsigned sum
        int         s;  // signed sum
        logic [7:0] r;
        logic       co;
        logic       ov;
        u  = 0;
        s  = 0;
        r  = 8'h00;
        co = 1'b0;
        ov = 1'b0;
        case (op)
            ADC: begin
                u  = int'(x) + int'(y) + int'(cin);
                s  = int'($signed(x)) + int'($signed(y)) + int'(cin);
                r  = u[7:0];
                co = (u > 255);
                ov = (s > 127) || (s < -128);
            end
            SBC: begin
                u  = int'(x) + (255 - int'(y)) + int'(cin); // borrow when c is 0
                s  = int'($signed(x)) - int'($signed(y)) - 1 + int'(cin);
                r  = u[7:0];
                co = (u > 255);
                ov = (s > 127) || (s < -128);
            end
            AND:     r = x & y;
            ORA:     r = x | y;
            EOR:     r = x ^ y;
            ASL: begin
                r  = x << 1;
                co = x[7];
            end
            LSR: begin
                r  = x >> 1;
                co = x[0];
            end
            ROL: begin
                r  = (x << 1) | {7'd0, cin};
                co = x[7];
            end
            ROR: begin
                r  = (x >> 1) | {cin, 7'd0};
                co = x[0];
            end
            default: r = y; // pass b
        endcase
        return {ov, co, r};
    endfunction

    // flags the model expects after the coming edge
    task automatic update_model(input uop_code_e code, input alu_op_e op, input logic [9:0] m);
        case (code)
            ALU: begin
                model_q.flags.z = (m[7:0] == 8'h00);
                model_q.flags.n = m[7];
                if (op == ADC || op == SBC) begin
                    model_q.flags.c = m[8];
                    model_q.flags.v = m[9];
                end else if (op == ASL || op == LSR || op == ROL || op == ROR) begin
                    model_q.flags.c = m[8];
                end
            end
            PLP: begin
                model_q.flags.c = m[`FLAG_C];
                model_q.flags.z = m[`FLAG_Z];
                model_q.flags.i = m[`FLAG_I];
                model_q.flags.d = m[`FLAG_D];
                model_q.flags.v = m[`FLAG_V];
                model_q.flags.n = m[`FLAG_N];
            end
            CLC:     model_q.flags.c = 1'b0;
            SEC:     model_q.flags.c = 1'b1;
            CLI:     model_q.flags.i = 1'b0;
            SEI:     model_q.flags.i = 1'b1;
            CLD:     model_q.flags.d = 1'b0;
            SED:     model_q.flags.d = 1'b1;
            CLV:     model_q.flags.v = 1'b0;
            default: model_q = model_q; // nop holds
        endcase
    endtask

    function automatic psr_t psr_expect(input logic bk);
        psr_t p;
        p = model_q;
        p.flags.b = bk; // break level on 4 and 5
        p.flags.u = bk;
        return p;
    endfunction

    task automatic check_psr(input string name, input int cls, input psr_t exp);
        if (psr !== exp) begin
            $display("ERROR %s: expected %h actual %h", name, exp.bits, psr.bits);
            errs[cls] = errs[cls] + 1;
        end
    endtask

    // one micro-op per call
    // checks last edge, drives, checks result, advances model
    task automatic step(input uop_code_e code, input alu_op_e op, input logic [7:0] av,
                        input logic [7:0] bv, input logic bk);
        logic [9:0] m;
        @(negedge clk);
        check_psr(last_name, last_cls, psr_expect(brk));
        uop.code   = code;
        uop.alu_op = op;
        a          = av;
        b          = bv;
        brk        = bk;
        #1;
        check_psr("break_level", T_BRK, psr_expect(bk)); // only bits 5 and 4 may move
        m = alu_model(op, av, bv, model_q.flags.c);
        if (result !== m[7:0]) begin
            $display("ERROR alu_result: expected %h actual %h", m[7:0], result);
            errs[T_RESULT] = errs[T_RESULT] + 1;
        end
        update_model(code, op, m);
        if (code == ALU) begin
            last_name = "arith_flags";
            last_cls  = T_ARITH;
        end else if (code == PLP || code == NOP) begin
            last_name = "plp_nop";
            last_cls  = T_PLP;
        end else begin
            last_name = "set_clear";
            last_cls  = T_SETCLR;
        end
    endtask

    initial begin
        logic [3:0] k;
        logic [3:0] t;
        uop_code_e  rc;
        alu_op_e    ro;
        int         total;
        clk        = 1'b0;
        nrst       = 1'b0;
        uop.code   = NOP;
        uop.alu_op = ADC;
        a          = 8'h00;
        b          = 8'h00;
        brk        = 1'b0;
        rng        = 32'd86;
        model_q    = '0;
        cycles     = 0;
        last_name  = "plp_nop";
        last_cls   = T_PLP;
        foreach (errs[j]) begin
            errs[j] = 0;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_psr("reset", T_RESET, psr_expect(1'b0));
        brk = 1'b1;
        #1;
        check_psr("reset", T_RESET, psr_expect(1'b1)); // brk visible during reset
        nrst = 1'b1;
        brk  = 1'b0;

        // set and clear ops touch one flag each
        step(SEC, PASS_B, 8'h00, 8'h00, 1'b0);
        step(SEI, PASS_B, 8'h00, 8'h00, 1'b0);
        step(SED, PASS_B, 8'h00, 8'h00, 1'b0);
        step(ALU, ADC, 8'h50, 8'h50, 1'b0);  // 0x50+0x50+1 sets v and n
        step(CLV, PASS_B, 8'h00, 8'h00, 1'b0);
        step(CLC, PASS_B, 8'h00, 8'h00, 1'b0);
        step(CLI, PASS_B, 8'h00, 8'h00, 1'b0);
        step(CLD, PASS_B, 8'h00, 8'h00, 1'b0);
        // carry-in chain
        step(SEC, PASS_B, 8'h00, 8'h00, 1'b0);
        step(ALU, ADC, 8'h10, 8'h20, 1'b0);
        step(SEC, PASS_B, 8'h00, 8'h00, 1'b0);
        step(ALU, ROL, 8'h80, 8'h00, 1'b0);
        step(ALU, ROR, 8'h01, 8'h00, 1'b0);
        step(ALU, SBC, 8'h00, 8'h01, 1'b0);  // borrow out
        // plp and nop hold
        step(PLP, PASS_B, 8'h00, 8'hff, 1'b0);
        step(NOP, AND, 8'h00, 8'h00, 1'b0);
        step(PLP, PASS_B, 8'h00, 8'h00, 1'b1);
        step(NOP, EOR, 8'h00, 8'h00, 1'b1);
        // break level toggles
        step(NOP, PASS_B, 8'h00, 8'h00, 1'b0);
        step(NOP, PASS_B, 8'h00, 8'h00, 1'b1);
        step(NOP, PASS_B, 8'h00, 8'h00, 1'b0);

        for (int n = 0; n < N_RAND; n++) begin
            rng = xorshift(rng);
            k   = rng[7:4] % 4'd9;
            t   = rng[11:8] % 4'd10;
            ro  = alu_op_e'(t);
            if (rng[0]) begin
                rc = ALU;
            end else if (k == 4'd0) begin
                rc = NOP;
            end else begin
                rc = uop_code_e'(k + 4'd1); // plp up to clv
            end
            if (rc == PLP) ro = PASS_B;
            step(rc, ro, rng[19:12], rng[27:20], rng[29]);
        end

        @(negedge clk);
        check_psr(last_name, last_cls, psr_expect(brk));
        total = 0;
        foreach (errs[j]) begin
            total = total + errs[j];
        end
        $display("errors: reset %0d result %0d arith %0d setclr %0d plp %0d brk %0d",
                 errs[T_RESET], errs[T_RESULT], errs[T_ARITH], errs[T_SETCLR],
                 errs[T_PLP], errs[T_BRK]);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
